/* verilog/glay_pkg.sv */
package glay_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------
  localparam int ADDR_BITS       = 32;
  localparam int WORD_BITS       = 32;
  localparam int CONFIG_WORDS    = 8;
  localparam int OUTSTANDING_MAX = 4;
  // Must hold every read in flight
  localparam int RESP_FIFO_DEPTH = 4;

  // Derived counter and pointer widths
  localparam int WORD_IDX_BITS    = $clog2(CONFIG_WORDS);
  localparam int WORD_CNT_BITS    = $clog2(CONFIG_WORDS + 1);
  localparam int OUTSTANDING_BITS = $clog2(OUTSTANDING_MAX + 1);
  localparam int FIFO_PTR_BITS    = $clog2(RESP_FIFO_DEPTH);
  localparam int FIFO_CNT_BITS    = $clog2(RESP_FIFO_DEPTH + 1);

  // ----------------------------------------
  // Vector types
  // ----------------------------------------
  typedef logic [ADDR_BITS-1:0]        mem_addr_t;
  typedef logic [WORD_BITS-1:0]        config_word_t;
  typedef logic [WORD_IDX_BITS-1:0]    word_idx_t;
  typedef logic [WORD_CNT_BITS-1:0]    word_count_t;
  typedef logic [OUTSTANDING_BITS-1:0] outstanding_t;
  typedef logic [FIFO_PTR_BITS-1:0]    fifo_ptr_t;
  typedef logic [FIFO_CNT_BITS-1:0]    fifo_count_t;

  // ----------------------------------------
  // Bundles
  // ----------------------------------------
  // Host control, start and continue strobes
  typedef struct packed {
    logic ap_start;
    logic ap_continue;
  } control_in_t;

  typedef struct packed {
    logic ap_ready;
    logic ap_done;
    logic ap_idle;
  } control_out_t;

  typedef struct packed {
    logic      valid;
    mem_addr_t base_addr;
  } descriptor_t;

  // Word read strobe
  typedef struct packed {
    logic      valid;
    mem_addr_t addr;
  } mem_req_t;

  // In-order read data strobe
  typedef struct packed {
    logic         valid;
    config_word_t data;
  } mem_resp_t;

  // Word 0 first, word 7 last
  typedef struct packed {
    config_word_t vertex_count;
    config_word_t edge_count;
    config_word_t out_degree_base;
    config_word_t in_degree_base;
    config_word_t edges_idx_base;
    config_word_t edges_src_base;
    config_word_t edges_dest_base;
    config_word_t auxiliary;
  } graph_config_t;

  // Kernel control FSM
  typedef enum logic [1:0] {
    ctrl_idle,
    ctrl_busy,
    ctrl_done
  } control_state_e;

endpackage

/* verilog/glay_response_fifo.sv */
`timescale 1ns/1ps

module glay_response_fifo import glay_pkg::*; (
  input  logic         ap_clk,
  input  logic         control_areset,
  input  logic         push,
  input  config_word_t push_data,
  input  logic         pop,
  output config_word_t pop_data,
  output logic         empty
);

  config_word_t fifo_mem [RESP_FIFO_DEPTH];
  fifo_ptr_t    wr_ptr;
  fifo_ptr_t    rd_ptr;
  fifo_count_t  count;
  logic         full;

  assign empty = count == '0;
  assign full  = count == fifo_count_t'(RESP_FIFO_DEPTH);

  // Head entry visible without a read cycle
  assign pop_data = fifo_mem[rd_ptr];

  // ----------------------------------------
  // Storage
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= push_data;
    end
  end

  // ----------------------------------------
  // Pointers and occupancy
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Wrap at depth, any depth works
      if (push) begin
        wr_ptr <= (wr_ptr == fifo_ptr_t'(RESP_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == fifo_ptr_t'(RESP_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  // Credit cap upstream keeps this from filling over
  no_push_full_a : assert property (
    @(posedge ap_clk) disable iff (control_areset)
    push |-> !full
  ) else $error("response FIFO push while full");

  no_pop_empty_a : assert property (
    @(posedge ap_clk) disable iff (control_areset)
    pop |-> !empty
  ) else $error("response FIFO pop while empty");

endmodule

/* verilog/glay_request_generator.sv */
`timescale 1ns/1ps

module glay_request_generator import glay_pkg::*; (
  input  logic     ap_clk,
  input  logic     control_areset,
  input  mem_req_t req_in,
  input  logic     resp_pop,
  output mem_req_t mem_req,
  output logic     credit
);

  outstanding_t outstanding_count;

  // ----------------------------------------
  // Request register
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      mem_req.valid <= 1'b0;
    end else begin
      mem_req.valid <= req_in.valid;
    end
  end

  // Address is payload only
  always_ff @(posedge ap_clk) begin
    mem_req.addr <= req_in.addr;
  end

  // ----------------------------------------
  // Outstanding count
  // ----------------------------------------
  // Up on each issue, down on each pop
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      outstanding_count <= '0;
    end else begin
      case ({req_in.valid, resp_pop})
        2'b10: begin
          outstanding_count <= outstanding_count + 1'b1;
        end
        2'b01: begin
          outstanding_count <= outstanding_count - 1'b1;
        end
        default: begin
          outstanding_count <= outstanding_count;
        end
      endcase
    end
  end

  // Room for one more read
  assign credit = outstanding_count < outstanding_t'(OUTSTANDING_MAX);

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  // Requester honours credit, so the cap holds
  outstanding_cap_a : assert property (
    @(posedge ap_clk) disable iff (control_areset)
    outstanding_count <= outstanding_t'(OUTSTANDING_MAX)
  ) else $error("outstanding reads above the cap");

  // A pop needs a read in flight
  pop_has_read_a : assert property (
    @(posedge ap_clk) disable iff (control_areset)
    resp_pop |-> outstanding_count != '0
  ) else $error("response popped with no read outstanding");

endmodule

/* verilog/glay_kernel_setup.sv */
`timescale 1ns/1ps

module glay_kernel_setup import glay_pkg::*; (
  input  logic          ap_clk,
  input  logic          control_areset,
  input  logic          setup_start,
  input  mem_addr_t     setup_base,
  input  logic          credit,
  output mem_req_t      req,
  input  logic          fifo_empty,
  input  config_word_t  fifo_data,
  output logic          fifo_pop,
  output graph_config_t graph_config,
  output logic          setup_done
);

  logic         issue_active;
  word_count_t  issue_count;
  word_count_t  recv_count;
  config_word_t config_words [CONFIG_WORDS];

  // ----------------------------------------
  // Issue side
  // ----------------------------------------
  // Offer a read only with a free credit
  assign req.valid = issue_active && credit;
  assign req.addr  = setup_base + mem_addr_t'(issue_count);

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      issue_active <= 1'b0;
      issue_count  <= '0;
    end else if (setup_start) begin
      issue_active <= 1'b1;
      issue_count  <= '0;
    end else if (req.valid) begin
      issue_count <= issue_count + 1'b1;
      // Last word of the block sent
      if (issue_count == word_count_t'(CONFIG_WORDS - 1)) begin
        issue_active <= 1'b0;
      end
    end
  end

  // ----------------------------------------
  // Receive side
  // ----------------------------------------
  // Drain the FIFO whenever it has data
  assign fifo_pop = !fifo_empty;

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      recv_count <= '0;
      setup_done <= 1'b0;
    end else begin
      setup_done <= 1'b0;
      if (setup_start) begin
        recv_count <= '0;
      end else if (fifo_pop) begin
        recv_count <= recv_count + 1'b1;
        // Done one cycle after the final pop
        if (recv_count == word_count_t'(CONFIG_WORDS - 1)) begin
          setup_done <= 1'b1;
        end
      end
    end
  end

  // Responses come back in order, so the count picks the field
  always_ff @(posedge ap_clk) begin
    if (fifo_pop) begin
      config_words[word_idx_t'(recv_count)] <= fifo_data;
    end
  end

  // Word order into named fields
  always_comb begin
    graph_config.vertex_count    = config_words[0];
    graph_config.edge_count      = config_words[1];
    graph_config.out_degree_base = config_words[2];
    graph_config.in_degree_base  = config_words[3];
    graph_config.edges_idx_base  = config_words[4];
    graph_config.edges_src_base  = config_words[5];
    graph_config.edges_dest_base = config_words[6];
    graph_config.auxiliary       = config_words[7];
  end

  // No pop beyond the block
  recv_in_range_a : assert property (
    @(posedge ap_clk) disable iff (control_areset)
    fifo_pop |-> recv_count < word_count_t'(CONFIG_WORDS)
  ) else $error("response popped past the configuration block");

endmodule

/* verilog/glay_kernel_control.sv */
`timescale 1ns/1ps

module glay_kernel_control import glay_pkg::*; (
  input  logic         ap_clk,
  input  logic         control_areset,
  input  control_in_t  control_in,
  input  descriptor_t  descriptor,
  input  logic         setup_done,
  output control_out_t control_out,
  output logic         setup_start,
  output mem_addr_t    setup_base
);

  control_state_e control_state;
  logic           start_accept;

  // Start only counts while idle and with a valid descriptor
  assign start_accept = (control_state == ctrl_idle) && control_in.ap_start && descriptor.valid;

  // ----------------------------------------
  // Control FSM
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      control_state        <= ctrl_idle;
      control_out.ap_ready <= 1'b0;
      control_out.ap_done  <= 1'b0;
      control_out.ap_idle  <= 1'b1;
      setup_start          <= 1'b0;
    end else begin
      // Strobes default low
      control_out.ap_ready <= 1'b0;
      setup_start          <= 1'b0;
      case (control_state)
        ctrl_idle: begin
          if (start_accept) begin
            control_state        <= ctrl_busy;
            control_out.ap_ready <= 1'b1;
            control_out.ap_idle  <= 1'b0;
            setup_start          <= 1'b1;
          end
        end
        ctrl_busy: begin
          // Extra starts dropped here
          if (setup_done) begin
            control_state       <= ctrl_done;
            control_out.ap_done <= 1'b1;
          end
        end
        ctrl_done: begin
          // Hold done until the host acknowledges
          if (control_in.ap_continue) begin
            control_state       <= ctrl_idle;
            control_out.ap_done <= 1'b0;
            control_out.ap_idle <= 1'b1;
          end
        end
        default: begin
          control_state <= ctrl_idle;
        end
      endcase
    end
  end

  // Base address held for the whole run
  always_ff @(posedge ap_clk) begin
    if (start_accept) begin
      setup_base <= descriptor.base_addr;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  // Setup engine only reports back during a run
  setup_done_in_run_a : assert property (
    @(posedge ap_clk) disable iff (control_areset)
    setup_done |-> control_state == ctrl_busy
  ) else $error("setup_done outside a run");

endmodule

/* verilog/glay_kernel_cu.sv */
`timescale 1ns/1ps

module glay_kernel_cu import glay_pkg::*; (
  input  logic          ap_clk,
  input  logic          control_areset,
  input  control_in_t   control_in,
  output control_out_t  control_out,
  input  descriptor_t   descriptor,
  output mem_req_t      mem_req,
  input  mem_resp_t     mem_resp,
  output graph_config_t graph_config
);

  control_in_t  control_in_reg;
  descriptor_t  descriptor_reg;
  control_out_t control_out_int;

  // Control to setup
  logic      setup_start;
  logic      setup_done;
  mem_addr_t setup_base;

  // Setup to memory path
  mem_req_t     setup_req;
  logic         credit;
  logic         fifo_empty;
  logic         fifo_pop;
  config_word_t fifo_data;

  // ----------------------------------------
  // Input register stage
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      control_in_reg       <= '0;
      descriptor_reg.valid <= 1'b0;
    end else begin
      control_in_reg       <= control_in;
      descriptor_reg.valid <= descriptor.valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    descriptor_reg.base_addr <= descriptor.base_addr;
  end

  // ----------------------------------------
  // Output register stage
  // ----------------------------------------
  // Idle high out of reset
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      control_out.ap_ready <= 1'b0;
      control_out.ap_done  <= 1'b0;
      control_out.ap_idle  <= 1'b1;
    end else begin
      control_out <= control_out_int;
    end
  end

  // ----------------------------------------
  // Blocks
  // ----------------------------------------
  glay_kernel_control control_i (
    .ap_clk        (ap_clk),
    .control_areset(control_areset),
    .control_in    (control_in_reg),
    .descriptor    (descriptor_reg),
    .setup_done    (setup_done),
    .control_out   (control_out_int),
    .setup_start   (setup_start),
    .setup_base    (setup_base)
  );

  glay_kernel_setup setup_i (
    .ap_clk        (ap_clk),
    .control_areset(control_areset),
    .setup_start   (setup_start),
    .setup_base    (setup_base),
    .credit        (credit),
    .req           (setup_req),
    .fifo_empty    (fifo_empty),
    .fifo_data     (fifo_data),
    .fifo_pop      (fifo_pop),
    .graph_config  (graph_config),
    .setup_done    (setup_done)
  );

  // Pop strobe doubles as the credit return
  glay_request_generator request_generator_i (
    .ap_clk        (ap_clk),
    .control_areset(control_areset),
    .req_in        (setup_req),
    .resp_pop      (fifo_pop),
    .mem_req       (mem_req),
    .credit        (credit)
  );

  // Every response strobe lands here
  glay_response_fifo response_fifo_i (
    .ap_clk        (ap_clk),
    .control_areset(control_areset),
    .push          (mem_resp.valid),
    .push_data     (mem_resp.data),
    .pop           (fifo_pop),
    .pop_data      (fifo_data),
    .empty         (fifo_empty)
  );

endmodule

/* tb/glay_mem_model.sv */
`timescale 1ns/1ps

module glay_mem_model import glay_pkg::*; (
  input  logic      ap_clk,
  input  logic      control_areset,
  input  mem_req_t  mem_req,
  output mem_resp_t mem_resp,
  output int        outstanding
);

  // Pending reads, oldest first
  mem_addr_t addr_q[$];
  int        due_q[$];
  int        cycle;
  int        last_due;
  int        issued;
  int        returned;
  int        due;
  mem_resp_t resp;

  // Content rule, hashed from the word address
  function automatic config_word_t word_at(mem_addr_t addr);
    return addr * 32'h9E37_79B1 + 32'h0000_1234;
  endfunction

  initial begin
    mem_resp    = '0;
    outstanding = 0;
  end

  always @(posedge ap_clk) begin
    if (control_areset) begin
      addr_q.delete();
      due_q.delete();
      cycle       = 0;
      last_due    = 0;
      issued      = 0;
      returned    = 0;
      mem_resp    <= '0;
      outstanding <= 0;
    end else begin
      cycle = cycle + 1;
      resp  = '0;
      // Oldest read answers once its delay is up
      if (due_q.size() > 0 && due_q[0] <= cycle) begin
        resp.valid = 1'b1;
        resp.data  = word_at(addr_q.pop_front());
        void'(due_q.pop_front());
        returned = returned + 1;
      end
      if (mem_req.valid) begin
        due = cycle + int'($urandom_range(6, 1));
        // Keep answers in request order
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        addr_q.push_back(mem_req.addr);
        due_q.push_back(due);
        issued = issued + 1;
      end
      mem_resp    <= resp;
      outstanding <= issued - returned;
    end
  end

endmodule

/* tb/glay_kernel_cu_tb.sv */
`timescale 1ns/1ps

module glay_kernel_cu_tb import glay_pkg::*; ();

  localparam int        TIMEOUT_CYCLES = 400;
  localparam int        SEED           = 39;
  localparam mem_addr_t FIRST_BASE     = 32'h0000_0100;

  logic          ap_clk;
  logic          control_areset;
  control_in_t   control_in;
  control_out_t  control_out;
  descriptor_t   descriptor;
  mem_req_t      mem_req;
  mem_resp_t     mem_resp;
  graph_config_t graph_config;
  int            outstanding;

  // Run bookkeeping shared by stimulus and compare process
  mem_addr_t     run_base;
  graph_config_t expected_cfg;
  int            runs_checked;
  int            ready_count;
  int            req_count;
  logic          done_prev;

  glay_kernel_cu dut_i (
    .ap_clk        (ap_clk),
    .control_areset(control_areset),
    .control_in    (control_in),
    .control_out   (control_out),
    .descriptor    (descriptor),
    .mem_req       (mem_req),
    .mem_resp      (mem_resp),
    .graph_config  (graph_config)
  );

  glay_mem_model mem_i (
    .ap_clk        (ap_clk),
    .control_areset(control_areset),
    .mem_req       (mem_req),
    .mem_resp      (mem_resp),
    .outstanding   (outstanding)
  );

  initial ap_clk = 1'b0;
  always #2 ap_clk = ~ap_clk;

  // ----------------------------------------
  // Reference and checks
  // ----------------------------------------
  // Word i of the block lives at base plus i
  function automatic graph_config_t expected_config(mem_addr_t base);
    config_word_t  words [CONFIG_WORDS];
    graph_config_t cfg;
    int            i;
    for (i = 0; i < CONFIG_WORDS; i++) begin
      words[i] = (base + mem_addr_t'(i)) * 32'h9E37_79B1 + 32'h0000_1234;
    end
    cfg.vertex_count    = words[0];
    cfg.edge_count      = words[1];
    cfg.out_degree_base = words[2];
    cfg.in_degree_base  = words[3];
    cfg.edges_idx_base  = words[4];
    cfg.edges_src_base  = words[5];
    cfg.edges_dest_base = words[6];
    cfg.auxiliary       = words[7];
    return cfg;
  endfunction

  task automatic fail_run(string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected));
    end
  endtask

  // Mask picks ready, done, idle bits in that order
  task automatic wait_for_control(string what, logic [2:0] mask, logic [2:0] value);
    int waited;
    waited = 0;
    @(posedge ap_clk);
    while ((control_out & mask) != value) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        fail_run($sformatf("timed out waiting for %s", what));
      end
      @(posedge ap_clk);
    end
  endtask

  task automatic wait_checked(int runs);
    int waited;
    waited = 0;
    while (runs_checked < runs) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        fail_run("timed out waiting for the result comparison");
      end
      @(posedge ap_clk);
    end
  endtask

  // One-cycle start with a valid descriptor
  task automatic start_run(mem_addr_t base);
    @(posedge ap_clk);
    run_base                 = base;
    control_in.ap_start      <= 1'b1;
    descriptor.valid         <= 1'b1;
    descriptor.base_addr     <= base;
    @(posedge ap_clk);
    control_in.ap_start      <= 1'b0;
    descriptor.valid         <= 1'b0;
    wait_for_control("ap_ready", 3'b100, 3'b100);
  endtask

  task automatic continue_run();
    @(posedge ap_clk);
    control_in.ap_continue <= 1'b1;
    @(posedge ap_clk);
    control_in.ap_continue <= 1'b0;
    wait_for_control("ap_done low and ap_idle high", 3'b011, 3'b001);
  endtask

  // ----------------------------------------
  // Compare process
  // ----------------------------------------
  always @(posedge ap_clk) begin
    if (control_areset) begin
      runs_checked = 0;
      ready_count  = 0;
      req_count    = 0;
      done_prev    = 1'b0;
    end else begin
      if (outstanding > OUTSTANDING_MAX) begin
        fail_run("more reads in flight than the outstanding cap allows");
      end
      // Each accepted start restarts the address sequence
      if (control_out.ap_ready) begin
        ready_count = ready_count + 1;
        req_count   = 0;
      end
      if (mem_req.valid) begin
        if (req_count >= CONFIG_WORDS) begin
          fail_run("read request issued beyond the configuration block");
        end
        check_value("mem_req.addr", mem_req.addr, run_base + mem_addr_t'(req_count));
        req_count = req_count + 1;
      end
      // Result compared on the rising edge of done
      if (control_out.ap_done && !done_prev) begin
        expected_cfg = expected_config(run_base);
        check_value("request count", req_count, CONFIG_WORDS);
        check_value("vertex_count", graph_config.vertex_count, expected_cfg.vertex_count);
        check_value("edge_count", graph_config.edge_count, expected_cfg.edge_count);
        check_value("out_degree_base", graph_config.out_degree_base,
                    expected_cfg.out_degree_base);
        check_value("in_degree_base", graph_config.in_degree_base,
                    expected_cfg.in_degree_base);
        check_value("edges_idx_base", graph_config.edges_idx_base,
                    expected_cfg.edges_idx_base);
        check_value("edges_src_base", graph_config.edges_src_base,
                    expected_cfg.edges_src_base);
        check_value("edges_dest_base", graph_config.edges_dest_base,
                    expected_cfg.edges_dest_base);
        check_value("auxiliary", graph_config.auxiliary, expected_cfg.auxiliary);
        runs_checked = runs_checked + 1;
      end
      done_prev = control_out.ap_done;
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    mem_addr_t second_base;
    int        seed_value;
    seed_value     = $urandom(SEED);
    run_base       = '0;
    control_areset = 1'b1;
    control_in     = '0;
    descriptor     = '0;
    repeat (2) @(posedge ap_clk);
    control_areset <= 1'b0;

    // Quiet after reset
    repeat (10) begin
      @(posedge ap_clk);
      check_value("ap_idle", 32'(control_out.ap_idle), 32'd1);
      check_value("ap_ready", 32'(control_out.ap_ready), 32'd0);
      check_value("ap_done", 32'(control_out.ap_done), 32'd0);
      check_value("mem_req.valid", 32'(mem_req.valid), 32'd0);
    end

    // First run at the fixed base
    start_run(FIRST_BASE);
    wait_for_control("ap_done", 3'b010, 3'b010);
    wait_checked(1);

    // Done holds without continue
    repeat (20) begin
      @(posedge ap_clk);
      check_value("ap_done", 32'(control_out.ap_done), 32'd1);
    end
    continue_run();

    // Second run, extra starts while busy
    second_base = $urandom;
    start_run(second_base);
    repeat (3) begin
      @(posedge ap_clk);
      control_in.ap_start  <= 1'b1;
      descriptor.valid     <= 1'b1;
      descriptor.base_addr <= second_base + 32'h0000_0040;
      @(posedge ap_clk);
      control_in.ap_start  <= 1'b0;
      descriptor.valid     <= 1'b0;
    end
    wait_for_control("ap_done", 3'b010, 3'b010);
    wait_checked(2);
    continue_run();

    // No stray reads once idle
    repeat (10) begin
      @(posedge ap_clk);
      check_value("mem_req.valid", 32'(mem_req.valid), 32'd0);
    end
    check_value("ap_ready pulses", ready_count, 32'd2);

    $display("all tests passed");
    $finish;
  end

endmodule

/* src.f */
verilog/glay_pkg.sv
verilog/glay_response_fifo.sv
verilog/glay_request_generator.sv
verilog/glay_kernel_setup.sv
verilog/glay_kernel_control.sv
verilog/glay_kernel_cu.sv
tb/glay_mem_model.sv
tb/glay_kernel_cu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the kernel CU simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=glay_kernel_cu_sim

verilator --binary --timing --assert -j 0 \
  --top-module glay_kernel_cu_tb \
  -f src.f \
  -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

# The log decides the result
if grep -q "tests failed" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0
